// File: dv/tb_exec_model.svh
// Reference model and random source for the execute stage testbench.
// Included inside the testbench module, after the exec_pkg import.
`ifndef TB_EXEC_MODEL_SVH
`define TB_EXEC_MODEL_SVH

// Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per call
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// ----------------------------------------
// Expected writeback payload for one request
// ----------------------------------------
function automatic ex_out_t model_result(input ex_in_t req);
    ex_out_t         r;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] c;
    logic            taken;
    a = req.opr_a;
    b = req.opr_b;
    c = req.opr_c;
    taken = 1'b0;
    r = '{rd: req.rd, uop: req.uop, fu: req.fu, trap: req.trap, size: req.size,
          opr_a: '0, opr_b: '0};
    case (req.fu)
        FU_ALU: begin
            case (req.uop)
                ALU_ADD:  r.opr_a = a + b;
                ALU_SUB:  r.opr_a = a - b;
                ALU_XOR:  r.opr_a = a ^ b;
                ALU_OR:   r.opr_a = a | b;
                ALU_AND:  r.opr_a = a & b;
                ALU_SLL:  r.opr_a = a << b[4:0];                // Low five bits only
                ALU_SRL:  r.opr_a = a >> b[4:0];
                ALU_SRA:  r.opr_a = $unsigned($signed(a) >>> b[4:0]);
                ALU_SLT:  r.opr_a = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                ALU_SLTU: r.opr_a = (a < b) ? 32'd1 : 32'd0;
                default:  r.opr_a = '0;
            endcase
        end
        FU_LSU: begin
            r.opr_a = a + b;                                    // Effective address
            if (req.uop[LSU_STORE_BIT]) r.opr_b = c;            // Store data
        end
        FU_CFU: begin
            case (req.uop)
                CFU_BEQ:  taken = (a == b);
                CFU_BNE:  taken = (a != b);
                CFU_BLT:  taken = ($signed(a) < $signed(b));
                CFU_BGE:  taken = ($signed(a) >= $signed(b));
                CFU_BLTU: taken = (a < b);
                CFU_BGEU: taken = (a >= b);
                default:  taken = 1'b0;
            endcase
            r.opr_a = c & ~32'd1;                               // PC-relative target
            if (req.uop == CFU_JALR) r.opr_a = (a + b) & ~32'd1;
            else if (req.uop != CFU_JALI) r.uop = taken ? CFU_TAKEN : CFU_NOT_TAKEN;
        end
        default: begin
            r.opr_a = a;                                        // CSR pass-through
            r.opr_b = c;
        end
    endcase
    if (req.trap) r.opr_b = {{(XLEN-REG_AW){1'b0}}, req.rd};    // Cause in operand B
    return r;
endfunction

`endif

// File: dv/tb_exec_stage.sv
// Testbench for the integer execute stage.
// Random requests and back-pressure from a fixed-seed LFSR, results checked
// against the reference model through a queue of pending results.
`default_nettype none

module tb_exec_stage import exec_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_REQ      = 2000;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_CYCLES   = NUM_REQ * 10;     // About three cycles per accept
    localparam logic [9:0][UOP_W-1:0] ALU_OPS = {ALU_SLTU, ALU_SLT, ALU_SRA, ALU_SRL,
        ALU_SLL, ALU_AND, ALU_OR, ALU_XOR, ALU_SUB, ALU_ADD};
    localparam logic [7:0][UOP_W-1:0] CFU_OPS = {CFU_JALR, CFU_JALI, CFU_BGEU, CFU_BLTU,
        CFU_BGE, CFU_BLT, CFU_BNE, CFU_BEQ};

    logic    g_clk;
    logic    g_resetn;
    ex_in_t  i_s2;
    logic    i_s2_valid;
    logic    o_s2_busy;
    logic    i_flush;
    ex_out_t o_s3;
    logic    o_s3_valid;
    logic    i_s3_busy;

    logic [31:0] lfsr_state;
    ex_out_t     exp_q [$];                         // Pending results, oldest first
    ex_out_t     held_s3;                           // Payload seen at a stall
    logic        held = 1'b0;                       // Last cycle was a stall
    logic        flushed = 1'b0;                    // Last cycle flushed
    int          cycles = 0;
    int          accepted = 0;
    int          retired = 0;
    int          err_data = 0;
    int          err_ctrl = 0;

    `include "tb_exec_model.svh"

    exec_stage i_dut (.g_clk(g_clk), .g_resetn(g_resetn), .i_s2(i_s2),
        .i_s2_valid(i_s2_valid), .o_s2_busy(o_s2_busy), .i_flush(i_flush),
        .o_s3(o_s3), .o_s3_valid(o_s3_valid), .i_s3_busy(i_s3_busy));

    initial begin
        g_clk = 1'b0;
        forever #4 g_clk = ~g_clk;                  // 8 ns period
    end

    always @(posedge g_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, %0d of %0d requests accepted",
                     cycles, accepted, NUM_REQ);
            $display("Test failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        int          k;
        v = '0;
        for (k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};           // One step per bit
        end
        return v;
    endfunction

    function automatic logic [UOP_W-1:0] pick_uop(input fu_e fu, input logic [4:0] r);
        case (fu)
            FU_ALU:  return ALU_OPS[4'(r % 5'd10)];
            FU_CFU:  return CFU_OPS[r[2:0]];
            FU_LSU:  return {r[0], ~r[0], r[3:1]};  // Store or load, never both
            default: return r;                      // CSR micro-op is opaque
        endcase
    endfunction

    function automatic ex_in_t random_request();
        ex_in_t      r;
        logic [31:0] t;
        t = take_bits(2);
        r.fu = fu_e'(4'b0001 << t[1:0]);
        t = take_bits(5);
        r.uop = pick_uop(r.fu, t[4:0]);
        r.opr_a = take_bits(32);
        t = take_bits(2);
        r.opr_b = (t[1:0] == 2'd0) ? r.opr_a : take_bits(32);  // Equal operands now and then
        r.opr_c = take_bits(32);
        t = take_bits(5);
        r.rd = t[4:0];
        t = take_bits(2);
        r.size = t[1:0];
        t = take_bits(4);
        r.trap = (t[3:0] == 4'd0);                  // 1 in 16
        return r;
    endfunction

    // ----------------------------------------
    // Checking
    // ----------------------------------------
    task automatic check_field(input string test, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            err_data++;
            $display("error %s: expected %h actual %h", test, exp, act);
        end
    endtask

    task automatic compare_result(input ex_out_t exp);
        string test;
        test = $sformatf("fu %b uop %b%s", exp.fu, exp.uop, exp.trap ? " trap" : "");
        check_field({test, " opr_a"}, exp.opr_a, o_s3.opr_a);
        check_field({test, " opr_b"}, exp.opr_b, o_s3.opr_b);
        check_field({test, " uop"}, 32'(exp.uop), 32'(o_s3.uop));
        check_field({test, " rd/fu/trap/size"}, 32'({exp.rd, exp.fu, exp.trap, exp.size}),
                    32'({o_s3.rd, o_s3.fu, o_s3.trap, o_s3.size}));
    endtask

    task automatic observe_output();
        if (o_s3_valid !== (exp_q.size() != 0)) begin
            err_ctrl++;
            $display("o_s3_valid is %b with %0d results pending%s", o_s3_valid,
                     exp_q.size(), flushed ? " after a flush" : "");
        end else if (o_s3_valid) begin
            compare_result(exp_q[0]);
        end
        if (held && o_s3 !== held_s3) begin
            err_ctrl++;
            $display("o_s3 changed while writeback was stalled");
        end
    endtask

    task automatic drive_cycle(input logic more);
        logic [31:0] t;
        logic        accept;
        i_s2 = random_request();
        t = take_bits(1);
        i_s2_valid = more && t[0];
        t = take_bits(1);
        i_s3_busy = t[0];
        t = take_bits(6);
        i_flush = (t[5:0] == 6'd0);                 // Rare flush
        #1;
        if (o_s2_busy !== (o_s3_valid && i_s3_busy)) begin
            err_ctrl++;
            $display("o_s2_busy is %b with o_s3_valid %b and i_s3_busy %b",
                     o_s2_busy, o_s3_valid, i_s3_busy);
        end
        accept  = i_s2_valid && !(o_s3_valid && i_s3_busy);
        held    = o_s3_valid && i_s3_busy && !i_flush;
        held_s3 = o_s3;
        flushed = i_flush;
        if (i_flush) begin
            exp_q.delete();                         // Flush drops everything in flight
        end else begin
            if (o_s3_valid && !i_s3_busy) begin
                void'(exp_q.pop_front());
                retired++;
            end
            if (accept) exp_q.push_back(model_result(i_s2));
        end
        if (accept) accepted++;
    endtask

    initial begin
        lfsr_state = 32'h3d53_ff4b;
        g_resetn   = 1'b0;
        i_s2       = '0;
        i_s2_valid = 1'b1;                          // Offered during reset, must be dropped
        i_flush    = 1'b0;
        i_s3_busy  = 1'b0;
        repeat (RESET_CYCLES) @(posedge g_clk);
        @(negedge g_clk);
        if (o_s3_valid !== 1'b0) begin
            err_ctrl++;
            $display("o_s3_valid is not low after reset");
        end
        i_s2_valid = 1'b0;
        g_resetn   = 1'b1;
        while (accepted < NUM_REQ || exp_q.size() != 0) begin
            @(negedge g_clk);
            observe_output();
            drive_cycle(accepted < NUM_REQ);        // Drain once all are sent
        end
        $display("Errors: %0d data, %0d control, %0d accepted, %0d retired",
                 err_data, err_ctrl, accepted, retired);
        if (err_data == 0 && err_ctrl == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f verilog.f --top-module tb_exec_stage

./obj_dir/Vtb_exec_stage | tee sim.log

if grep -qx "Test passed" sim.log; then
    exit 0
fi
exit 1

// File: src/exec_alu.sv
// Single-cycle integer ALU for the execute stage.
// Purely combinational. The sum and the compare flags are always valid,
// so the LSU and branch paths use them whatever the selected operation.
`default_nettype none

module exec_alu import exec_pkg::*; (
    input  logic [XLEN-1:0]  i_lhs,     // Left operand
    input  logic [XLEN-1:0]  i_rhs,     // Right operand
    input  logic [UOP_W-1:0] i_uop,     // ALU micro-op
    input  logic             i_en,      // ALU result in use
    output logic [XLEN-1:0]  o_result,  // Selected result
    output logic [XLEN-1:0]  o_sum,     // lhs + rhs
    output logic             o_lt,      // lhs < rhs
    output logic             o_eq       // lhs == rhs
);

    logic [XLEN:0]   diff;              // Extended difference, borrow on top
    logic            ltu;               // Unsigned less-than
    logic            lts;               // Signed less-than
    logic [4:0]      shamt;             // Shift amount
    logic [XLEN-1:0] res;               // Result before enable
    logic            op_known;          // Micro-op decoded

    // ----------------------------------------
    // Adder and compare
    // ----------------------------------------
    assign o_sum = i_lhs + i_rhs;
    assign diff  = {1'b0, i_lhs} - {1'b0, i_rhs};
    assign ltu   = diff[XLEN];          // Borrow out
    assign lts   = (i_lhs[XLEN-1] != i_rhs[XLEN-1]) ? i_lhs[XLEN-1] : ltu;
    assign o_eq  = (i_lhs == i_rhs);

    // Only SLTU asks for an unsigned compare, branches get mapped onto it
    assign o_lt  = (i_uop == ALU_SLTU) ? ltu : lts;

    assign shamt = i_rhs[4:0];          // Low five bits only

    // ----------------------------------------
    // Result select
    // ----------------------------------------
    always_comb begin
        op_known = 1'b1;
        case (i_uop)
            ALU_ADD:  res = o_sum;
            ALU_SUB:  res = diff[XLEN-1:0];
            ALU_XOR:  res = i_lhs ^ i_rhs;
            ALU_OR:   res = i_lhs | i_rhs;
            ALU_AND:  res = i_lhs & i_rhs;
            ALU_SLL:  res = i_lhs << shamt;
            ALU_SRL:  res = i_lhs >> shamt;
            ALU_SRA:  res = $unsigned($signed(i_lhs) >>> shamt);
            ALU_SLT:  res = {{(XLEN-1){1'b0}}, lts};
            ALU_SLTU: res = {{(XLEN-1){1'b0}}, ltu};
            default: begin
                res      = '0;
                op_known = 1'b0;        // Not an ALU code
            end
        endcase
    end

    assign o_result = i_en ? res : '0;  // Quiet when unused

    // Decode must hand a real ALU code whenever the result is taken
    always_comb begin
        assert final (!i_en || op_known)
            else $error("exec_alu: unknown micro-op %b", i_uop);
    end

endmodule

`default_nettype wire

// File: src/exec_branch.sv
// Branch resolution and jump target formation.
// Conditional branches leave as CFU_TAKEN or CFU_NOT_TAKEN from the ALU
// flags. Jumps pass their micro-op through. Combinational.
`default_nettype none

module exec_branch import exec_pkg::*; (
    input  logic             i_en,      // CFU op in the stage
    input  logic [UOP_W-1:0] i_uop,     // CFU micro-op
    input  logic             i_lt,      // ALU less-than
    input  logic             i_eq,      // ALU equal
    input  logic [XLEN-1:0]  i_opr_c,   // PC-relative target
    input  logic [XLEN-1:0]  i_sum,     // rs1 + imm for jalr
    output logic [UOP_W-1:0] o_uop,     // Resolved micro-op
    output logic [XLEN-1:0]  o_target,  // Jump / branch target
    output logic             o_unsigned // ALU compare unsigned
);

    logic cond;                         // Conditional branch
    logic taken;                        // Condition holds
    logic jalr;                         // Register-indirect jump

    // Kept apart from the flag logic, the ALU compare depends on it
    assign o_unsigned = i_en && (i_uop == CFU_BLTU || i_uop == CFU_BGEU);

    always_comb begin
        cond  = i_en;
        taken = 1'b0;
        case (i_uop)
            CFU_BEQ:            taken = i_eq;
            CFU_BNE:            taken = !i_eq;
            CFU_BLT, CFU_BLTU:  taken = i_lt;   // Same flag, sign set by ALU
            CFU_BGE, CFU_BGEU:  taken = !i_lt;
            CFU_JALI, CFU_JALR: cond  = 1'b0;   // Jumps go through as is
            default:            cond  = 1'b0;
        endcase
    end

    assign jalr  = i_en && (i_uop == CFU_JALR);

    assign o_uop = cond ? (taken ? CFU_TAKEN : CFU_NOT_TAKEN) : i_uop;

    // Targets are halfword aligned
    assign o_target = jalr ? {i_sum[XLEN-1:1], 1'b0}
                           : {i_opr_c[XLEN-1:1], 1'b0};

endmodule

`default_nettype wire

// File: src/exec_pipe_reg.sv
// Pipeline register between execute and writeback.
// Loads on i_valid when not busy, holds while the writeback side is busy.
// No skid buffer, so o_busy follows the downstream stall directly.
`default_nettype none

module exec_pipe_reg import exec_pkg::*; (
    input  logic    g_clk,
    input  logic    g_resetn,
    input  ex_out_t i_data,             // Next stage payload
    input  logic    i_valid,            // Upstream has data
    input  logic    i_flush,            // Drop contents
    input  logic    i_busy,             // Writeback stalled
    output ex_out_t o_data,             // Registered payload
    output logic    o_valid,            // Payload valid
    output logic    o_busy              // Stall upstream
);

    logic load;                         // Transfer this edge

    assign o_busy = o_valid && i_busy;  // Full and not draining
    assign load   = i_valid && !o_busy;

    // ----------------------------------------
    // Valid flag
    // ----------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            o_valid <= 1'b0;
        end else if (i_flush) begin
            o_valid <= 1'b0;            // Flush beats a load
        end else if (!o_busy) begin
            o_valid <= i_valid;         // Drain or refill
        end
    end

    // Payload
    always_ff @(posedge g_clk) begin
        if (load) begin
            o_data <= i_data;
        end
    end

    // A stalled result must not move under the writeback stage
    a_hold_stable : assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        (o_valid && i_busy) |=> $stable(o_data)
    ) else $error("exec_pipe_reg: o_data changed while held");

endmodule

`default_nettype wire

// File: src/exec_pkg.sv
// Shared definitions for the integer execute stage.
// Holds the data widths, the one-hot functional unit code, the micro-op
// encodings and the request/result structs. Modules import it in their header.
`default_nettype none

package exec_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int XLEN         = 32;   // Data path width
    localparam int REG_AW       = 5;    // Register address width
    localparam int UOP_W        = 5;    // Micro-op width
    localparam int TRAP_CAUSE_W = 6;    // Trap cause width

    // One-hot functional unit select
    typedef enum logic [3:0] {
        FU_ALU = 4'b0001,               // Integer ALU
        FU_LSU = 4'b0010,               // Load/store address gen
        FU_CFU = 4'b0100,               // Control flow
        FU_CSR = 4'b1000                // CSR access
    } fu_e;

    // ----------------------------------------
    // ALU micro-ops
    // ----------------------------------------
    localparam logic [UOP_W-1:0] ALU_ADD  = 5'b01001;
    localparam logic [UOP_W-1:0] ALU_SUB  = 5'b01000;
    localparam logic [UOP_W-1:0] ALU_XOR  = 5'b00001;
    localparam logic [UOP_W-1:0] ALU_OR   = 5'b00010;
    localparam logic [UOP_W-1:0] ALU_AND  = 5'b00100;
    localparam logic [UOP_W-1:0] ALU_SLL  = 5'b11001;   // Shift left logical
    localparam logic [UOP_W-1:0] ALU_SRL  = 5'b11010;   // Shift right logical
    localparam logic [UOP_W-1:0] ALU_SRA  = 5'b11100;   // Shift right arith
    localparam logic [UOP_W-1:0] ALU_SLT  = 5'b10001;   // Signed less-than
    localparam logic [UOP_W-1:0] ALU_SLTU = 5'b10010;   // Unsigned less-than

    // CFU micro-ops, conditional branches have uop[4:3] == 0
    localparam logic [UOP_W-1:0] CFU_BEQ       = 5'b00001;
    localparam logic [UOP_W-1:0] CFU_BGE       = 5'b00010;
    localparam logic [UOP_W-1:0] CFU_BGEU      = 5'b00011;
    localparam logic [UOP_W-1:0] CFU_BLT       = 5'b00100;
    localparam logic [UOP_W-1:0] CFU_BLTU      = 5'b00101;
    localparam logic [UOP_W-1:0] CFU_BNE       = 5'b00110;
    localparam logic [UOP_W-1:0] CFU_NOT_TAKEN = 5'b01000;  // Resolved, fall through
    localparam logic [UOP_W-1:0] CFU_TAKEN     = 5'b01001;  // Resolved, redirect
    localparam logic [UOP_W-1:0] CFU_JALI      = 5'b10010;  // Jump, immediate target
    localparam logic [UOP_W-1:0] CFU_JALR      = 5'b10100;  // Jump, register target

    // LSU micro-op flag positions
    localparam int LSU_LOAD_BIT  = 3;
    localparam int LSU_STORE_BIT = 4;

    // ----------------------------------------
    // Stage payloads
    // ----------------------------------------
    typedef struct packed {
        logic [REG_AW-1:0] rd;          // Destination register
        logic [XLEN-1:0]   opr_a;       // Operand A
        logic [XLEN-1:0]   opr_b;       // Operand B
        logic [XLEN-1:0]   opr_c;       // Operand C, store data / PC target
        logic [UOP_W-1:0]  uop;         // Micro-op
        fu_e               fu;          // Functional unit
        logic              trap;        // Raise a trap
        logic [1:0]        size;        // Instruction size
    } ex_in_t;

    typedef struct packed {
        logic [REG_AW-1:0] rd;          // Destination register
        logic [UOP_W-1:0]  uop;         // Micro-op, branches resolved
        fu_e               fu;          // Functional unit
        logic              trap;        // Raise a trap
        logic [1:0]        size;        // Instruction size
        logic [XLEN-1:0]   opr_a;       // Result / address / target
        logic [XLEN-1:0]   opr_b;       // Store data / CSR data / cause
    } ex_out_t;

endpackage

`default_nettype wire

// File: src/exec_stage.sv
// Integer execute stage top level.
// Decodes the one-hot unit, runs the ALU and branch logic, builds the
// writeback payload and registers it. One cycle from accept to o_s3.
// Back-pressure from writeback is the only stall source.
`default_nettype none

module exec_stage import exec_pkg::*; (
    input  logic    g_clk,
    input  logic    g_resetn,
    input  ex_in_t  i_s2,               // Decode request
    input  logic    i_s2_valid,         // Request valid
    output logic    o_s2_busy,          // Stage cannot accept
    input  logic    i_flush,            // Flush the stage
    output ex_out_t o_s3,               // Writeback payload
    output logic    o_s3_valid,         // Payload valid
    input  logic    i_s3_busy           // Writeback stalled
);

    // ----------------------------------------
    // Unit decode
    // ----------------------------------------
    logic fu_alu;
    logic fu_lsu;
    logic fu_cfu;
    logic fu_csr;
    logic lsu_load;                     // LSU load
    logic lsu_store;                    // LSU store

    assign fu_alu    = (i_s2.fu & FU_ALU) != 4'b0;
    assign fu_lsu    = (i_s2.fu & FU_LSU) != 4'b0;
    assign fu_cfu    = (i_s2.fu & FU_CFU) != 4'b0;
    assign fu_csr    = (i_s2.fu & FU_CSR) != 4'b0;
    assign lsu_load  = fu_lsu && i_s2.uop[LSU_LOAD_BIT];
    assign lsu_store = fu_lsu && i_s2.uop[LSU_STORE_BIT];

    // ----------------------------------------
    // ALU and branch
    // ----------------------------------------
    logic [UOP_W-1:0]        alu_uop;
    logic [XLEN-1:0]         alu_result;
    logic [XLEN-1:0]         alu_sum;
    logic                    alu_lt;
    logic                    alu_eq;
    logic [UOP_W-1:0]        br_uop;
    logic [XLEN-1:0]         br_target;
    logic                    br_unsigned;
    logic [TRAP_CAUSE_W-1:0] trap_cause;
    logic [XLEN-1:0]         n_opr_a;
    logic [XLEN-1:0]         n_opr_b;
    ex_out_t                 n_s3;

    // Non-ALU units borrow the comparator as SLT or SLTU
    assign alu_uop = fu_alu      ? i_s2.uop :
                     br_unsigned ? ALU_SLTU : ALU_SLT;

    exec_alu u_alu (
        .i_lhs    (i_s2.opr_a),
        .i_rhs    (i_s2.opr_b),
        .i_uop    (alu_uop),
        .i_en     (i_s2_valid && fu_alu),
        .o_result (alu_result),
        .o_sum    (alu_sum),            // Also the LSU address
        .o_lt     (alu_lt),
        .o_eq     (alu_eq)
    );

    exec_branch u_branch (
        .i_en       (fu_cfu),
        .i_uop      (i_s2.uop),
        .i_lt       (alu_lt),
        .i_eq       (alu_eq),
        .i_opr_c    (i_s2.opr_c),
        .i_sum      (alu_sum),
        .o_uop      (br_uop),
        .o_target   (br_target),
        .o_unsigned (br_unsigned)
    );

    // ----------------------------------------
    // Result select
    // ----------------------------------------
    assign trap_cause = TRAP_CAUSE_W'(i_s2.rd);     // Cause rides in rd

    assign n_opr_a = {XLEN{fu_alu}} & alu_result |
                     {XLEN{fu_lsu}} & alu_sum    |
                     {XLEN{fu_cfu}} & br_target  |
                     {XLEN{fu_csr}} & i_s2.opr_a;

    assign n_opr_b = i_s2.trap ? XLEN'(trap_cause) :
                     (lsu_store || fu_csr) ? i_s2.opr_c : '0;

    always_comb begin
        n_s3.rd    = i_s2.rd;
        n_s3.uop   = fu_cfu ? br_uop : i_s2.uop;
        n_s3.fu    = i_s2.fu;
        n_s3.trap  = i_s2.trap;
        n_s3.size  = i_s2.size;
        n_s3.opr_a = n_opr_a;
        n_s3.opr_b = n_opr_b;
    end

    exec_pipe_reg u_pipe_reg (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_data   (n_s3),
        .i_valid  (i_s2_valid),
        .i_flush  (i_flush),
        .i_busy   (i_s3_busy),
        .o_data   (o_s3),
        .o_valid  (o_s3_valid),
        .o_busy   (o_s2_busy)           // No buffering, stall passes up
    );

    // Decode hands over exactly one unit per request
    a_fu_onehot : assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        i_s2_valid |-> $onehot(i_s2.fu)
    ) else $error("exec_stage: fu not one-hot %b", i_s2.fu);

    // An LSU op is either a load or a store
    a_lsu_dir : assert property (
        @(posedge g_clk) disable iff (!g_resetn)
        (i_s2_valid && fu_lsu) |-> (lsu_load != lsu_store)
    ) else $error("exec_stage: LSU uop %b has no single direction", i_s2.uop);

endmodule

`default_nettype wire

// File: verilog.f
+incdir+dv
src/exec_pkg.sv
src/exec_alu.sv
src/exec_branch.sv
src/exec_pipe_reg.sv
src/exec_stage.sv
dv/tb_exec_stage.sv
